//--- rpi_bus_pkg.sv
// #########################################################################
// host bus constants for the parallel peripheral: bus width, halfwords per
// data word and error counter width, referenced as rpi_bus_pkg::name
// #########################################################################
`default_nettype none

package rpi_bus_pkg;

	localparam int BUS_WIDTH = 16; // host data bus
	localparam int TRANSACTIONS_PER_DATA_WORD = 2; // most significant halfword first
	localparam int DATA_WIDTH = BUS_WIDTH * TRANSACTIONS_PER_DATA_WORD;
	localparam int ERROR_COUNT_WIDTH = 8; // counters wrap

endpackage

`default_nettype wire

//--- register_map_pkg.sv
// #########################################################################
// register map of the peripheral: bank layout, status bank offsets and
// the address word, which decodes either flat or as bank plus offset
// #########################################################################
`default_nettype none

package register_map_pkg;

	localparam int BANK_BITS = 2; // four banks
	localparam int NUMBER_OF_BANKS = 2 ** BANK_BITS;
	localparam int OFFSET_WIDTH = rpi_bus_pkg::BUS_WIDTH - BANK_BITS;

	localparam logic [BANK_BITS-1:0] STATUS_BANK = 2'd3; // read only

	// rows of the status bank
	localparam logic [OFFSET_WIDTH-1:0] READ_ERRORS_OFFSET = 'd0;
	localparam logic [OFFSET_WIDTH-1:0] WRITE_ERRORS_OFFSET = 'd1;
	localparam logic [OFFSET_WIDTH-1:0] ADDRESS_ERRORS_OFFSET = 'd2;

	typedef struct packed {
		logic [BANK_BITS-1:0] bank; // top address bits
		logic [OFFSET_WIDTH-1:0] offset;
	} bank_offset_t;

	// flat view is loaded from the bus and incremented,
	// field view selects the bank and the row
	typedef union packed {
		logic [rpi_bus_pkg::BUS_WIDTH-1:0] flat;
		bank_offset_t field;
	} register_address_t;

endpackage

`default_nettype wire

//--- register_access_if.sv
// #########################################################################
// register access between the bus engine and the bank memory; the bus
// engine drives address, strobes, write data and counts, memory answers
// #########################################################################
`timescale 1ns/10ps
`default_nettype none

interface register_access_if;

	register_map_pkg::register_address_t address;
	logic [register_map_pkg::NUMBER_OF_BANKS-1:0] write_strobe; // one clock per word
	logic [rpi_bus_pkg::DATA_WIDTH-1:0] write_data;
	logic [rpi_bus_pkg::DATA_WIDTH-1:0] read_data; // combinational from address
	logic [rpi_bus_pkg::ERROR_COUNT_WIDTH-1:0] read_errors;
	logic [rpi_bus_pkg::ERROR_COUNT_WIDTH-1:0] write_errors;
	logic [rpi_bus_pkg::ERROR_COUNT_WIDTH-1:0] address_errors;

	modport bus_side (
		output address, write_strobe, write_data,
		output read_errors, write_errors, address_errors,
		input read_data
	);

	modport memory_side (
		input address, write_strobe, write_data,
		input read_errors, write_errors, address_errors,
		output read_data
	);

endinterface

`default_nettype wire

//--- half_duplex_rpi_bus.sv
// #########################################################################
// peripheral side of the half duplex host bus: synchronizes the host
// levels, builds address and data words and drives the bus on reads
// #########################################################################
`timescale 1ns/10ps
`default_nettype none

module half_duplex_rpi_bus #(
	parameter int ANTI_META = 3, // two oldest stages form the edge detector
	parameter int ADDRESS_AUTOINCREMENT = 1
) (
	input logic clock,
	input logic reset,
	inout wire [rpi_bus_pkg::BUS_WIDTH-1:0] bus,
	input logic read, // 0=write 1=read
	input logic register_select, // 0=address 1=data
	input logic enable,
	output logic ack_valid,
	register_access_if.bus_side regs
);

	localparam int BW = rpi_bus_pkg::BUS_WIDTH;
	localparam int DW = rpi_bus_pkg::DATA_WIDTH;
	localparam int HALVES = rpi_bus_pkg::TRANSACTIONS_PER_DATA_WORD;
	localparam int HALF_BITS = $clog2(HALVES);
	localparam logic [HALF_BITS-1:0] FIRST_HALF = HALF_BITS'(HALVES - 1);

	logic [ANTI_META:0] enable_pipeline;
	logic [ANTI_META:0] read_pipeline;
	logic [ANTI_META:0] select_pipeline;
	logic [BW-1:0] bus_pipeline [ANTI_META+1];
	logic [BW-1:0] bus_sample;

	logic en_now;
	logic en_prev;
	logic en_rise;
	logic en_fall;
	logic en_low;
	logic read_mode;
	logic write_mode;
	logic data_select;
	logic address_select;

	// per-phase capture flags, cleared on the falling enable
	logic a_cap;
	logic w_cap;
	logic r_cap;
	logic [HALF_BITS-1:0] wword;
	logic [HALF_BITS-1:0] rword;

	logic take_read;
	logic take_data;
	logic take_address;
	logic write_partial;
	logic read_partial;
	logic abandon_write;
	logic abandon_read;
	logic abandon_address;

	logic [BW-1:0] address_stage;
	logic [DW-1:0] read_buffer;
	logic [BW-1:0] bus_drive;
	logic ready; // a word finished, read buffer may reload
	logic increment_pending;

	assign en_now = enable_pipeline[ANTI_META-1];
	assign en_prev = enable_pipeline[ANTI_META];
	assign en_rise = en_now & ~en_prev;
	assign en_fall = ~en_now & en_prev;
	assign en_low = ~en_now & ~en_prev;

	// modes count only when both detector stages agree
	assign read_mode = &read_pipeline[ANTI_META -: 2];
	assign write_mode = ~|read_pipeline[ANTI_META -: 2];
	assign data_select = &select_pipeline[ANTI_META -: 2];
	assign address_select = ~|select_pipeline[ANTI_META -: 2];
	assign bus_sample = bus_pipeline[ANTI_META];

	assign take_read = en_now & read_mode & ~r_cap;
	assign take_data = en_now & write_mode & data_select & ~w_cap;
	assign take_address = en_now & write_mode & address_select & ~a_cap;

	assign write_partial = w_cap | (wword != FIRST_HALF);
	assign read_partial = r_cap | (rword != FIRST_HALF);
	assign abandon_write = (take_read | take_address) & write_partial;
	assign abandon_read = (take_data | take_address) & read_partial;
	assign abandon_address = (take_read | take_data) & a_cap;

	assign bus = read ? bus_drive : 'z; // host owns the bus on writes

	always_ff @(posedge clock) begin
		bus_pipeline[0] <= bus;
		for (int i = 1; i <= ANTI_META; i++) begin
			bus_pipeline[i] <= bus_pipeline[i-1];
		end
		if (take_data) begin
			regs.write_data[wword*BW +: BW] <= bus_sample;
		end
		if (take_address) begin
			address_stage <= bus_sample;
		end
		if (en_low && ready) begin
			read_buffer <= regs.read_data; // follows the address until next read
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			enable_pipeline <= '0;
			read_pipeline <= '0;
			select_pipeline <= '0;
			ack_valid <= 1'b0;
			regs.write_strobe <= '0;
			regs.address <= '0;
			regs.read_errors <= '0;
			regs.write_errors <= '0;
			regs.address_errors <= '0;
			a_cap <= 1'b0;
			w_cap <= 1'b0;
			r_cap <= 1'b0;
			wword <= FIRST_HALF;
			rword <= FIRST_HALF;
			ready <= 1'b0;
			increment_pending <= 1'b0;
			bus_drive <= '0;
		end else begin
			enable_pipeline <= {enable_pipeline[ANTI_META-1:0], enable};
			read_pipeline <= {read_pipeline[ANTI_META-1:0], read};
			select_pipeline <= {select_pipeline[ANTI_META-1:0], register_select};
			ack_valid <= en_now & (read_mode | (write_mode & (data_select | address_select)));
			regs.write_strobe <= '0;
			if (en_rise) begin
				ready <= 1'b0;
			end
			if (increment_pending) begin
				increment_pending <= 1'b0;
				if (ADDRESS_AUTOINCREMENT != 0) begin
					regs.address.flat <= regs.address.flat + 1'b1;
				end
			end

			// a new kind of transaction drops any partial word of another kind
			if (abandon_write) begin
				w_cap <= 1'b0;
				wword <= FIRST_HALF;
				regs.write_errors <= regs.write_errors + 1'b1;
			end
			if (abandon_read) begin
				r_cap <= 1'b0;
				rword <= FIRST_HALF;
				regs.read_errors <= regs.read_errors + 1'b1;
			end
			if (abandon_address) begin
				a_cap <= 1'b0;
				regs.address_errors <= regs.address_errors + 1'b1;
			end

			if (take_read) begin
				r_cap <= 1'b1;
				bus_drive <= read_buffer[rword*BW +: BW];
			end
			if (take_data) begin
				w_cap <= 1'b1;
			end
			if (take_address) begin
				a_cap <= 1'b1;
			end

			if (en_fall) begin
				if (w_cap) begin
					w_cap <= 1'b0;
					if (wword == '0) begin
						regs.write_strobe[regs.address.field.bank] <= 1'b1;
						wword <= FIRST_HALF;
						ready <= 1'b1;
						increment_pending <= 1'b1; // after the strobe has used the address
					end else begin
						wword <= wword - 1'b1;
					end
				end
				if (r_cap) begin
					r_cap <= 1'b0;
					if (rword == '0) begin
						rword <= FIRST_HALF;
						ready <= 1'b1;
						increment_pending <= 1'b1;
					end else begin
						rword <= rword - 1'b1;
					end
				end
				if (a_cap) begin
					a_cap <= 1'b0;
					regs.address.flat <= address_stage; // single halfword address
					ready <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- pollable_bank_memory.sv
// #########################################################################
// bank memory behind the bus engine: three writable banks of 32-bit rows
// plus a read-only status bank with the protocol error counters
// #########################################################################
`timescale 1ns/10ps
`default_nettype none

module pollable_bank_memory #(
	parameter int OFFSET_BITS = 4 // rows per bank as a power of two
) (
	input logic clock,
	input logic reset,
	register_access_if.memory_side regs
);

	localparam int DW = rpi_bus_pkg::DATA_WIDTH;
	localparam int ROWS = 2 ** OFFSET_BITS;
	localparam int WRITABLE_BANKS = int'(register_map_pkg::STATUS_BANK); // banks below status

	logic [DW-1:0] rows [WRITABLE_BANKS][ROWS];
	logic [register_map_pkg::BANK_BITS-1:0] bank;
	logic [OFFSET_BITS-1:0] row;

	assign bank = regs.address.field.bank;
	assign row = regs.address.field.offset[OFFSET_BITS-1:0]; // upper offset bits alias

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int b = 0; b < WRITABLE_BANKS; b++) begin
				for (int r = 0; r < ROWS; r++) begin
					rows[b][r] <= '0;
				end
			end
		end else begin
			// strobe bit of the status bank has no array behind it
			for (int b = 0; b < WRITABLE_BANKS; b++) begin
				if (regs.write_strobe[b]) begin
					rows[b][row] <= regs.write_data;
				end
			end
		end
	end

	always_comb begin
		regs.read_data = '0;
		if (bank == register_map_pkg::STATUS_BANK) begin
			case (regs.address.field.offset)
				register_map_pkg::READ_ERRORS_OFFSET: begin
					regs.read_data = DW'(regs.read_errors);
				end
				register_map_pkg::WRITE_ERRORS_OFFSET: begin
					regs.read_data = DW'(regs.write_errors);
				end
				register_map_pkg::ADDRESS_ERRORS_OFFSET: begin
					regs.read_data = DW'(regs.address_errors);
				end
				default: begin
					regs.read_data = '0; // unused status rows
				end
			endcase
		end else begin
			regs.read_data = rows[bank][row];
		end
	end

endmodule

`default_nettype wire

//--- rpi_peripheral_top.sv
// #########################################################################
// top of the parallel bus peripheral; connect the host bus pins here and
// set synchronizer depth, autoincrement and rows per bank by parameter
// #########################################################################
`timescale 1ns/10ps
`default_nettype none

module rpi_peripheral_top #(
	parameter int ANTI_META = 3,
	parameter int ADDRESS_AUTOINCREMENT = 1,
	parameter int OFFSET_BITS = 4
) (
	input logic clock,
	input logic reset,
	inout wire [rpi_bus_pkg::BUS_WIDTH-1:0] bus,
	input logic read,
	input logic register_select,
	input logic enable,
	output logic ack_valid
);

	register_access_if regs ();

	// host side, words and error counts
	half_duplex_rpi_bus #(
		.ANTI_META(ANTI_META),
		.ADDRESS_AUTOINCREMENT(ADDRESS_AUTOINCREMENT)
	) bus_engine (
		.clock(clock),
		.reset(reset),
		.bus(bus),
		.read(read),
		.register_select(register_select),
		.enable(enable),
		.ack_valid(ack_valid),
		.regs(regs.bus_side)
	);

	pollable_bank_memory #(
		.OFFSET_BITS(OFFSET_BITS)
	) bank_memory (
		.clock(clock),
		.reset(reset),
		.regs(regs.memory_side)
	);

endmodule

`default_nettype wire

//--- rpi_peripheral_tb.sv
// #########################################################################
// testbench for the parallel bus peripheral: replays the golden vector
// file as host bus transactions and checks read words and ack_valid
// #########################################################################
`timescale 1ns/10ps
`default_nettype none

module rpi_peripheral_tb;

	localparam int BW = rpi_bus_pkg::BUS_WIDTH;
	localparam int DW = rpi_bus_pkg::DATA_WIDTH;
	localparam int OFFSET_BITS = 4;
	localparam int ROWS = 2 ** OFFSET_BITS;
	localparam int MAX_VECTORS = 128;
	localparam int VECTOR_BITS = 4 + 2 * DW; // op, value, expected

	logic clock;
	logic reset;
	wire [BW-1:0] bus;
	logic read;
	logic register_select;
	logic enable;
	logic ack_valid;
	logic host_drive; // host side of the shared bus
	logic [BW-1:0] host_value;

	logic [VECTOR_BITS-1:0] vectors [0:MAX_VECTORS-1];
	logic [DW-1:0] bank_model [0:2][0:ROWS-1]; // writable banks only
	logic [BW-1:0] host_address; // follows autoincrement
	integer seed;
	int cycle_count = 0;
	int cycle_limit = 2000;
	int check_count;
	int error_count;
	int test_checks;
	int test_errors;

	rpi_peripheral_top #(
		.ANTI_META(3),
		.ADDRESS_AUTOINCREMENT(1),
		.OFFSET_BITS(OFFSET_BITS)
	) DUT (
		.clock(clock),
		.reset(reset),
		.bus(bus),
		.read(read),
		.register_select(register_select),
		.enable(enable),
		.ack_valid(ack_valid)
	);

	assign bus = host_drive ? host_value : 'z;

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: golden vectors not finished after %0d clocks", cycle_count);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	task automatic expect_word(input string name, input logic [DW-1:0] actual,
			input logic [DW-1:0] expected);
		check_count++;
		test_checks++;
		assert (actual === expected) else begin
			$display("CHECK FAILED at %0t ns: %s expected %h, got %h",
				$time, name, expected, actual);
			error_count++;
			test_errors++;
		end
	endtask

	// one halfword, enable 8 clocks high then 8 clocks low
	task automatic bus_transaction(input logic is_read, input logic select,
			input logic [BW-1:0] value, input logic turn_to_data,
			output logic [BW-1:0] sampled);
		@(posedge clock);
		#2;
		read = is_read;
		register_select = select;
		host_drive = ~is_read; // peripheral drives while read is high
		host_value = value;
		@(posedge clock);
		#2;
		enable = 1'b1;
		if (turn_to_data) begin
			repeat (8) @(posedge clock);
			#2;
			register_select = 1'b1; // address phase becomes a data halfword
		end
		repeat (8) @(posedge clock);
		#1;
		sampled = bus;
		expect_word("ack_valid", DW'(ack_valid), DW'(1'b1));
		#1;
		enable = 1'b0;
		repeat (8) @(posedge clock);
		#1;
		expect_word("ack_valid", DW'(ack_valid), '0);
		#1;
	endtask

	task automatic load_address(input logic [BW-1:0] address);
		logic [BW-1:0] unused;
		bus_transaction(1'b0, 1'b0, address, 1'b0, unused);
		host_address = address;
	endtask

	task automatic store_word(input logic [DW-1:0] word);
		logic [BW-1:0] unused;
		bus_transaction(1'b0, 1'b1, word[DW-1 -: BW], 1'b0, unused); // high half first
		bus_transaction(1'b0, 1'b1, word[BW-1:0], 1'b0, unused);
		if (host_address[BW-1 -: 2] != register_map_pkg::STATUS_BANK) begin
			bank_model[host_address[BW-1 -: 2]][host_address[OFFSET_BITS-1:0]] = word;
		end
		host_address = host_address + 1'b1;
	endtask

	task automatic fetch_word(output logic [DW-1:0] word);
		logic [BW-1:0] high_half;
		logic [BW-1:0] low_half;
		bus_transaction(1'b1, 1'b1, '0, 1'b0, high_half);
		bus_transaction(1'b1, 1'b1, '0, 1'b0, low_half);
		word = {high_half, low_half};
		host_address = host_address + 1'b1;
	endtask

	initial begin : stimulus
		logic [3:0] op;
		logic [DW-1:0] value;
		logic [DW-1:0] expected;
		logic [DW-1:0] word;
		logic [BW-1:0] halfword;
		int index;
		int transactions;
		logic finished;
		reset = 1'b1;
		enable = 1'b0;
		read = 1'b0;
		register_select = 1'b0;
		host_drive = 1'b1;
		host_value = '0;
		host_address = '0;
		seed = 94396;
		check_count = 0;
		error_count = 0;
		test_checks = 0;
		test_errors = 0;
		for (int b = 0; b < 3; b++) begin
			for (int r = 0; r < ROWS; r++) begin
				bank_model[b][r] = '0; // reset clears every row
			end
		end
		$readmemh("rpi_golden_vectors.txt", vectors);

		// run limit from the number of bus transactions in the file
		transactions = 0;
		index = 0;
		while (index < MAX_VECTORS && vectors[index][VECTOR_BITS-1 -: 4] !== 4'hf) begin
			case (vectors[index][VECTOR_BITS-1 -: 4])
				4'h1, 4'h4, 4'h5: transactions += 1;
				4'h2, 4'h3, 4'h6, 4'h7, 4'h8: transactions += 2;
				default: ;
			endcase
			index++;
		end
		cycle_limit = 20 * transactions + 100;

		repeat (3) @(posedge clock);
		#2;
		reset = 1'b0;

		index = 0;
		finished = 1'b0;
		while (!finished && index < MAX_VECTORS) begin
			{op, value, expected} = vectors[index];
			index++;
			case (op)
				4'h0: begin
					$display("test %0d finished: %0d checks, %0d errors",
						value, test_checks, test_errors);
					test_checks = 0;
					test_errors = 0;
				end
				4'h1: load_address(value[BW-1:0]);
				4'h2: store_word(value);
				4'h3: begin
					fetch_word(word);
					expect_word("bus", word, expected);
				end
				4'h4: bus_transaction(1'b0, 1'b1, value[BW-1:0], 1'b0, halfword);
				4'h5: bus_transaction(1'b1, 1'b1, '0, 1'b0, halfword);
				4'h6: bus_transaction(1'b0, 1'b0, value[BW-1:0], 1'b1, halfword);
				4'h7: store_word($random(seed));
				4'h8: begin
					expected = bank_model[host_address[BW-1 -: 2]][host_address[OFFSET_BITS-1:0]];
					fetch_word(word);
					expect_word("bus", word, expected);
				end
				4'hf: finished = 1'b1;
				default: begin
					$display("vector %0d holds an unknown operation %h", index - 1, op);
					error_count++;
					finished = 1'b1;
				end
			endcase
		end
		if (!finished) begin
			$display("the vector file has no end line");
			error_count++;
		end

		$display("all tests: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- rpi_golden_vectors.txt
// op_value_expected in hex. op 1 address, 2 data word, 3 read and compare, 4 write halfword,
// 5 read halfword, 6 address phase turned data, 7 random word, 8 read against model, 0 end of test, f end
1_0000c000_00000000 // status counters after reset
3_00000000_00000000
3_00000000_00000000
3_00000000_00000000
0_00000001_00000000
1_00000005_00000000 // single words in banks 0 and 2
2_12345678_00000000
1_00000005_00000000
3_00000000_12345678
1_00008007_00000000
2_a5a55a5a_00000000
1_00008007_00000000
3_00000000_a5a55a5a
0_00000002_00000000
1_00004008_00000000 // burst in bank 1
2_11111111_00000000
2_22222222_00000000
2_33333333_00000000
1_00004008_00000000
3_00000000_11111111
3_00000000_22222222
3_00000000_33333333
0_00000003_00000000
1_00008002_00000000 // aliasing rows and a write to the status bank
7_00000000_00000000
1_00008012_00000000
8_00000000_00000000
1_00008022_00000000
8_00000000_00000000
1_0000c001_00000000
2_ffffffff_00000000
1_0000c001_00000000
3_00000000_00000000
0_00000004_00000000
1_00000002_00000000 // partial write, then address
4_0000beef_00000000
1_0000c001_00000000
3_00000000_00000001
5_00000000_00000000 // partial read, then address
1_0000c000_00000000
3_00000000_00000001
6_00001234_00000000 // address phase interrupted by data
4_0000abcd_00000000
1_0000c000_00000000
3_00000000_00000001
3_00000000_00000001
3_00000000_00000001
0_00000005_00000000
f_00000000_00000000

//--- project.f
rpi_bus_pkg.sv
register_map_pkg.sv
register_access_if.sv
half_duplex_rpi_bus.sv
pollable_bank_memory.sv
rpi_peripheral_top.sv
rpi_peripheral_tb.sv
